// ==== fft_params.svh ====
`ifndef FFT_PARAMS_SVH
`define FFT_PARAMS_SVH

// Frame length, a power of two. 4, 8 and 16 are supported.
`define FFT_N 8

// Width of one signed fixed-point sample.
`define FFT_WIDTH 32

// Fraction bits of a sample.
`define FFT_FRAC 16

`endif

// ==== fft_pkg.sv ====
package fft_pkg;

  `include "fft_params.svh"

  localparam int FFT_LOG2N = $clog2(`FFT_N);  // Number of butterfly stages.
  localparam int FFT_ONE = 1 << `FFT_FRAC;    // Fixed-point code of 1.0.
  localparam real FFT_PI = 3.14159265358979323846;

  // One signed fixed-point value.
  typedef logic signed [`FFT_WIDTH-1:0] sample_t;

  // Full-width product of two samples.
  typedef logic signed [2*`FFT_WIDTH-1:0] prod_t;

  typedef struct packed {
    sample_t re;
    sample_t im;
  } cplx_t;

  typedef sample_t [`FFT_N-1:0] real_frame_t;
  typedef cplx_t [`FFT_N-1:0] cplx_frame_t;

  // Real part of W^k = exp(-j*2*pi*k/N).
  function automatic sample_t fft_twiddle_re(input int k);
    real ang;
    ang = -2.0 * FFT_PI * real'(k) / real'(`FFT_N);
    return sample_t'(int'($cos(ang) * real'(FFT_ONE)));
  endfunction

  // Imaginary part of W^k.
  function automatic sample_t fft_twiddle_im(input int k);
    real ang;
    ang = -2.0 * FFT_PI * real'(k) / real'(`FFT_N);
    return sample_t'(int'($sin(ang) * real'(FFT_ONE)));
  endfunction

  // Reverse the low log2(N) bits of k.
  function automatic int fft_bit_rev(input int k);
    int r;
    r = 0;
    for (int i = 0; i < FFT_LOG2N; i++) begin
      r = (r << 1) | ((k >> i) & 1);
    end
    return r;
  endfunction

endpackage

// ==== fft_butterfly.sv ====
`timescale 1ns/1ps

`include "fft_params.svh"

module fft_butterfly
  import fft_pkg::*;
#(
  parameter int TW_INDEX = 0
) (
  input  cplx_t a,
  input  cplx_t b,
  output cplx_t sum,
  output cplx_t diff
);

  // Twiddle codes, fixed at elaboration.
  localparam sample_t TW_RE = fft_twiddle_re(TW_INDEX);
  localparam sample_t TW_IM = fft_twiddle_im(TW_INDEX);

  cplx_t prod;  // b * W, back at FFT_FRAC fraction bits.

  generate
    if (TW_INDEX == 0) begin : g_unity
      // W = 1 exactly, no rounding error from the twiddle.
      assign prod = b;
    end else begin : g_mult
      prod_t rr;
      prod_t ii;
      prod_t ri;
      prod_t ir;
      prod_t acc_re;
      prod_t acc_im;

      assign rr = b.re * TW_RE;
      assign ii = b.im * TW_IM;
      assign ri = b.re * TW_IM;
      assign ir = b.im * TW_RE;

      // Complex multiply at full width.
      assign acc_re = rr - ii;
      assign acc_im = ri + ir;

      // Arithmetic shift floors toward negative infinity.
      assign prod.re = sample_t'(acc_re >>> `FFT_FRAC);
      assign prod.im = sample_t'(acc_im >>> `FFT_FRAC);
    end
  endgenerate

  // Sums wrap on overflow.
  assign sum.re  = a.re + prod.re;
  assign sum.im  = a.im + prod.im;
  assign diff.re = a.re - prod.re;
  assign diff.im = a.im - prod.im;

endmodule

// ==== fft_stage.sv ====
`timescale 1ns/1ps

`include "fft_params.svh"

module fft_stage
  import fft_pkg::*;
#(
  parameter int STAGE = 0
) (
  input  logic        clk,
  input  logic        rst_n,

  input  cplx_frame_t in_frame,
  input  logic        in_valid,
  output logic        in_ready,

  output cplx_frame_t out_frame,
  output logic        out_valid,
  input  logic        out_ready
);

  localparam int HALF  = 1 << STAGE;      // Distance between paired elements.
  localparam int GROUP = 2 * HALF;        // Elements per butterfly group.
  localparam int TW_STEP = `FFT_N / GROUP;

  cplx_frame_t bf_frame;  // Butterfly results, before the register.
  cplx_frame_t frame_q;
  logic        valid_q;
  logic        accept;

  generate
    for (genvar j = 0; j < `FFT_N / 2; j++) begin : g_bf
      localparam int POS   = j % HALF;
      localparam int IDX_A = (j / HALF) * GROUP + POS;
      localparam int IDX_B = IDX_A + HALF;

      fft_butterfly #(
        .TW_INDEX(POS * TW_STEP)
      ) u_bf (
        .a   (in_frame[IDX_A]),
        .b   (in_frame[IDX_B]),
        .sum (bf_frame[IDX_A]),
        .diff(bf_frame[IDX_B])
      );
    end
  endgenerate

  // Room when empty or when the held frame leaves this cycle.
  assign in_ready = !valid_q || out_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;  // Drains when nothing new arrives.
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      frame_q <= bf_frame;
    end
  end

  assign out_frame = frame_q;
  assign out_valid = valid_q;

endmodule

// ==== fft_core.sv ====
`timescale 1ns/1ps

`include "fft_params.svh"

module fft_core
  import fft_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  input  real_frame_t in_frame,
  input  logic        in_valid,
  output logic        in_ready,

  output cplx_frame_t out_frame,
  output logic        out_valid,
  input  logic        out_ready
);

  // Link s feeds stage s; the last link is the output.
  cplx_frame_t link_frame [FFT_LOG2N+1];
  logic        link_valid [FFT_LOG2N+1];
  logic        link_ready [FFT_LOG2N+1];

  // Bit-reversed load, real input only.
  generate
    for (genvar k = 0; k < `FFT_N; k++) begin : g_rev
      assign link_frame[0][k].re = in_frame[fft_bit_rev(k)];
      assign link_frame[0][k].im = '0;
    end
  endgenerate

  assign link_valid[0] = in_valid;
  assign in_ready      = link_ready[0];

  generate
    for (genvar s = 0; s < FFT_LOG2N; s++) begin : g_stage
      fft_stage #(
        .STAGE(s)
      ) u_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_frame (link_frame[s]),
        .in_valid (link_valid[s]),
        .in_ready (link_ready[s]),
        .out_frame(link_frame[s+1]),
        .out_valid(link_valid[s+1]),
        .out_ready(link_ready[s+1])
      );
    end
  endgenerate

  assign out_frame             = link_frame[FFT_LOG2N];
  assign out_valid             = link_valid[FFT_LOG2N];
  assign link_ready[FFT_LOG2N] = out_ready;

endmodule

// ==== fft_core_chk.sv ====
`timescale 1ns/1ps

module fft_core_chk
  import fft_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        in_valid,
  input logic        in_ready,
  input cplx_frame_t out_frame,
  input logic        out_valid,
  input logic        out_ready
);

  int unsigned fail_count = 0;  // Read by the testbench at the end of each test.

  logic accept;

  assign accept = in_valid && in_ready;

  // Output idle one cycle after a reset edge.
  reset_idle: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else begin
      $error("out_valid is high in the cycle after reset");
      fail_count++;
    end

  // A stalled output keeps its valid.
  stall_valid: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid)
    else begin
      $error("out_valid dropped while the output was stalled");
      fail_count++;
    end

  // A stalled output keeps its data.
  stall_frame: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> $stable(out_frame))
    else begin
      $error("out_frame changed while the output was stalled");
      fail_count++;
    end

  // Three register stages with no stall in between.
  latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(accept, 3) && $past(out_ready, 3) && $past(out_ready, 2) && $past(out_ready, 1)
    |-> out_valid)
    else begin
      $error("accepted frame did not reach out_valid three cycles later");
      fail_count++;
    end

endmodule

bind fft_core fft_core_chk u_chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .in_valid (in_valid),
  .in_ready (in_ready),
  .out_frame(out_frame),
  .out_valid(out_valid),
  .out_ready(out_ready)
);

// ==== tb_fft_core.sv ====
`timescale 1ns/1ps

`include "fft_params.svh"

module tb_fft_core
  import fft_pkg::*;
();

  localparam real PI = 3.14159265358979323846;
  localparam int ONE = 1 << `FFT_FRAC;
  localparam int RAND_FRAMES = 20;
  localparam int BP_FRAMES = 24;
  localparam int TOTAL_FRAMES = 6 + RAND_FRAMES + BP_FRAMES;
  localparam int DRAIN_LIMIT = 200;  // Cycles allowed for the pipeline to empty.
  localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * 20 + 500;

  logic        clk;
  logic        rst_n;
  real_frame_t in_frame;
  logic        in_valid;
  logic        in_ready;
  cplx_frame_t out_frame;
  logic        out_valid;
  logic        out_ready;

  integer seed = 32'h802a;
  int     errors = 0;
  int     errors_at_start = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;
  int     cycle = 0;
  int     in_count = 0;
  int     out_count = 0;
  int     accept_cycle = 0;
  int     out_cycle = 0;
  logic   bp_active = 1'b0;

  // Expected frames in input order with their tolerance and check mode.
  cplx_frame_t exp_q[$];
  int          tol_q[$];
  bit          bin0_q[$];

  real_frame_t bp_frames [BP_FRAMES];

  fft_core u_fft_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_frame (in_frame),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_frame(out_frame),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic int error_total();
    return errors + int'(u_fft_core.u_chk.fail_count);
  endfunction

  function automatic void check_value(string name, sample_t got, sample_t exp, int tol);
    int diff;
    diff = int'(got) - int'(exp);
    assert (diff <= tol && diff >= -tol) else begin
      $display("CHECK FAILED time=%0t signal=%s got=%0d expected=%0d", $time, name, got, exp);
      errors++;
    end
  endfunction

  function automatic void check_output();
    cplx_frame_t exp_f;
    int          tol;
    int          last;
    if (exp_q.size() == 0) begin
      $display("Output frame at time %0t arrived with no frame pending", $time);
      errors++;
      return;
    end
    exp_f = exp_q.pop_front();
    tol = tol_q.pop_front();
    last = bin0_q.pop_front() ? 0 : `FFT_N - 1;
    for (int k = 0; k <= last; k++) begin
      check_value($sformatf("out_frame[%0d].re", k), out_frame[k].re, exp_f[k].re, tol);
      check_value($sformatf("out_frame[%0d].im", k), out_frame[k].im, exp_f[k].im, tol);
    end
  endfunction

  // Handshakes as seen at the clock edge.
  always @(posedge clk) begin
    cycle++;
    if (in_valid && in_ready) begin
      in_count++;
      accept_cycle = cycle;
    end
    if (out_valid && out_ready) begin
      out_count++;
      out_cycle = cycle;
      check_output();
    end
  end

  // Random consumer stalls.
  always @(negedge clk) begin
    if (bp_active) begin
      out_ready = ($random(seed) & 1) != 0;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 8);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  function automatic sample_t rand_sample(int range);
    return sample_t'($random(seed) % range);
  endfunction

  function automatic real_frame_t random_frame();
    real_frame_t x;
    for (int n = 0; n < `FFT_N; n++) begin
      x[n] = rand_sample(2 * ONE);  // Within +-2.0.
    end
    return x;
  endfunction

  // Direct DFT in real math rounded to codes.
  function automatic cplx_frame_t dft_ref(real_frame_t x);
    cplx_frame_t y;
    real         acc_re;
    real         acc_im;
    real         ang;
    for (int k = 0; k < `FFT_N; k++) begin
      acc_re = 0.0;
      acc_im = 0.0;
      for (int n = 0; n < `FFT_N; n++) begin
        ang = 2.0 * PI * real'((n * k) % `FFT_N) / real'(`FFT_N);
        acc_re = acc_re + real'(x[n]) * $cos(ang);
        acc_im = acc_im - real'(x[n]) * $sin(ang);
      end
      y[k].re = sample_t'(int'(acc_re));
      y[k].im = sample_t'(int'(acc_im));
    end
    return y;
  endfunction

  function automatic cplx_frame_t flat_spectrum(sample_t level);
    cplx_frame_t y;
    for (int k = 0; k < `FFT_N; k++) begin
      y[k].re = level;
      y[k].im = '0;
    end
    return y;
  endfunction

  // Spectrum with one real bin and zeros elsewhere.
  function automatic cplx_frame_t single_bin(int bin, sample_t level);
    cplx_frame_t y;
    y = '0;
    y[bin].re = level;
    return y;
  endfunction

  function automatic cplx_frame_t dc_sum(real_frame_t x);
    sample_t acc;
    acc = '0;
    for (int n = 0; n < `FFT_N; n++) begin
      acc = acc + x[n];
    end
    return single_bin(0, acc);
  endfunction

  // Called on a falling edge and returns on the falling edge after acceptance.
  task automatic send_frame(real_frame_t x, cplx_frame_t exp_f, int tol, bit bin0_only);
    int target;
    exp_q.push_back(exp_f);
    tol_q.push_back(tol);
    bin0_q.push_back(bin0_only);
    target = in_count + 1;
    in_frame = x;
    in_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (in_count < target);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (out_count < in_count && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (out_count < in_count) begin
      $display("Timed out at %0t with %0d frames still inside the pipeline",
               $time, in_count - out_count);
      errors++;
    end
  endtask

  task automatic start_test();
    errors_at_start = error_total();
  endtask

  task automatic end_test(string name);
    if (error_total() == errors_at_start) begin
      tests_passed++;
      $display("[%0t] %s: passed", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] %s: FAILED with %0d errors", $time, name,
               error_total() - errors_at_start);
    end
  endtask

  initial begin
    real_frame_t x;
    sample_t     a;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_frame = '0;
    out_ready = 1'b0;  // Stalled, so in_ready comes only from empty stages.
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test();
    check_value("out_valid", out_valid, 0, 0);
    check_value("in_ready", in_ready, 1, 0);
    out_ready = 1'b1;
    x = random_frame();
    send_frame(x, dft_ref(x), 8, 1'b0);
    in_valid = 1'b0;
    wait_drain();
    check_value("out_valid latency", out_cycle - accept_cycle, 3, 0);
    end_test("reset and latency");

    start_test();
    x = '0;
    x[0] = sample_t'(ONE);
    send_frame(x, flat_spectrum(sample_t'(ONE)), 0, 1'b0);
    in_valid = 1'b0;
    wait_drain();
    end_test("impulse");

    start_test();
    for (int i = 0; i < 2; i++) begin
      a = (i == 0) ? sample_t'(3 * ONE / 4) : rand_sample(ONE);
      for (int n = 0; n < `FFT_N; n++) begin
        x[n] = a;
      end
      send_frame(x, single_bin(0, sample_t'(`FFT_N * a)), 0, 1'b0);
      for (int n = 0; n < `FFT_N; n++) begin
        x[n] = (n % 2 == 0) ? a : -a;
      end
      send_frame(x, single_bin(`FFT_N / 2, sample_t'(`FFT_N * a)), 0, 1'b0);
    end
    in_valid = 1'b0;
    wait_drain();
    end_test("dc and alternating");

    start_test();
    for (int i = 0; i < RAND_FRAMES; i++) begin
      x = random_frame();
      send_frame(x, dft_ref(x), 8, 1'b0);
    end
    in_valid = 1'b0;
    wait_drain();
    end_test("random frames");

    start_test();
    for (int i = 0; i < BP_FRAMES; i++) begin
      bp_frames[i] = random_frame();
    end
    @(posedge clk);
    bp_active = 1'b1;
    @(negedge clk);
    for (int i = 0; i < BP_FRAMES; i++) begin
      send_frame(bp_frames[i], dc_sum(bp_frames[i]), 0, 1'b1);
    end
    in_valid = 1'b0;
    wait_drain();
    @(posedge clk);
    bp_active = 1'b0;
    @(negedge clk);
    out_ready = 1'b1;
    end_test("back-pressure");

    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0 && error_total() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== fft_core.f ====
+incdir+.
fft_pkg.sv
fft_butterfly.sv
fft_stage.sv
fft_core.sv
fft_core_chk.sv
tb_fft_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FFT testbench with Verilator, then scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fft_core -f fft_core.f \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_fft_core +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
